// ==== rtl/cnn_pkg.sv ====
// Shared widths, address type and sequencer states of the 2-D convolution engine
package cnn_pkg;

  // ============================================================
  // Data and address widths
  // ============================================================
  localparam int ADDR_W     = 16;                  // Memory address width
  localparam int PIX_W      = 8;                   // Pixel, weight and result byte
  localparam int KERNEL_DIM = 4;                   // Kernel side, bytes per row segment
  localparam int ROW_W      = PIX_W * KERNEL_DIM;  // One row segment bus
  localparam int ACC_W      = 32;                  // Accumulator and bias

  // Width of a kernel row index
  localparam int IDX_W = (KERNEL_DIM > 1) ? $clog2(KERNEL_DIM) : 1;

  typedef logic [ADDR_W-1:0] addr_t;

  // ============================================================
  // Sequencer FSM
  // ============================================================
  typedef enum logic [2:0]
  {
    IDLE   = 3'd0,  // Waiting for go
    LOAD   = 3'd1,  // Kernel and bias load, first window fetch overlaps
    FETCH  = 3'd2,  // Window in flight, waiting for its result
    WRITE  = 3'd3,  // Result byte write handshake
    FINISH = 3'd4   // Done pulse cycle
  } cnn_state_t;

endpackage

// ==== rtl/cnn_window_fetch.sv ====
// Picture window fetcher, reads the row segments of one window and hands them out in order
module cnn_window_fetch #(
  parameter int PIC_COLS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          win_start,
  input  cnn_pkg::addr_t                win_base,
  input  logic                          kernel_ready,
  output logic                          pic_req,
  output cnn_pkg::addr_t                pic_addr,
  input  logic                          pic_ack,
  input  logic [cnn_pkg::ROW_W-1:0]     pic_data,
  output logic                          row_valid,
  output logic [cnn_pkg::ROW_W-1:0]     pic_row,
  output logic [cnn_pkg::IDX_W-1:0]     row_idx
);

  localparam cnn_pkg::addr_t ROW_STRIDE = cnn_pkg::addr_t'(PIC_COLS);
  localparam logic [cnn_pkg::IDX_W-1:0] LAST_ROW = cnn_pkg::IDX_W'(cnn_pkg::KERNEL_DIM - 1);

  logic                        rd_active;   // Window rows still to read
  logic [cnn_pkg::IDX_W-1:0]   rd_idx;      // Row being read
  cnn_pkg::addr_t              row_addr;    // Address of the row being read
  logic                        buf_full;
  logic [cnn_pkg::ROW_W-1:0]   buf_row;
  logic [cnn_pkg::IDX_W-1:0]   buf_idx;

  assign pic_addr = row_addr;

  // ============================================================
  // Row reads, four-phase handshake
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_active <= 1'b0;
      rd_idx    <= '0;
      pic_req   <= 1'b0;
    end
    else if (win_start)
    begin
      rd_active <= 1'b1;
      rd_idx    <= '0;
    end
    else if (pic_req && pic_ack)
    begin
      pic_req <= 1'b0;            // Drop req once ack is seen
      rd_idx  <= rd_idx + 1'b1;
      if (rd_idx == LAST_ROW)
        rd_active <= 1'b0;
    end
    else if (rd_active && !pic_req && !pic_ack && !buf_full)
    begin
      pic_req <= 1'b1;            // Ack seen low and buffer free
    end
  end

  // Next row sits one picture row further down
  always_ff @(posedge clk)
  begin
    if (win_start)
      row_addr <= win_base;
    else if (pic_req && pic_ack)
      row_addr <= row_addr + ROW_STRIDE;
  end

  // ============================================================
  // One-entry row buffer, released once the kernel is loaded
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      buf_full  <= 1'b0;
      row_valid <= 1'b0;
    end
    else
    begin
      row_valid <= buf_full && kernel_ready;
      if (pic_req && pic_ack)
        buf_full <= 1'b1;
      else if (buf_full && kernel_ready)
        buf_full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pic_req && pic_ack)
    begin
      buf_row <= pic_data;
      buf_idx <= rd_idx;
    end
    if (buf_full && kernel_ready)
    begin
      pic_row <= buf_row;
      row_idx <= buf_idx;
    end
  end

endmodule

// ==== rtl/cnn_kernel_load.sv ====
// Kernel loader, fetches the weight rows and the bias once per job and serves them by row index
module cnn_kernel_load (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          job_start,
  input  cnn_pkg::addr_t                addr_w,
  input  cnn_pkg::addr_t                addr_bias,
  output logic                          wgt_req,
  output cnn_pkg::addr_t                wgt_addr,
  output logic                          bias_req,
  output cnn_pkg::addr_t                bias_addr,
  input  logic                          wgt_ack,
  input  logic [cnn_pkg::ROW_W-1:0]     wgt_data,
  input  logic                          bias_ack,
  input  logic [cnn_pkg::ACC_W-1:0]     bias_data,
  input  logic [cnn_pkg::IDX_W-1:0]     row_idx,
  output logic                          kernel_ready,
  output logic [cnn_pkg::ROW_W-1:0]     kernel_row,
  output logic [cnn_pkg::ACC_W-1:0]     bias_val
);

  localparam cnn_pkg::addr_t WGT_STRIDE = cnn_pkg::addr_t'(cnn_pkg::KERNEL_DIM);
  localparam logic [cnn_pkg::IDX_W-1:0] LAST_ROW = cnn_pkg::IDX_W'(cnn_pkg::KERNEL_DIM - 1);

  logic [cnn_pkg::ROW_W-1:0]  kern_mem [cnn_pkg::KERNEL_DIM];
  logic [cnn_pkg::ACC_W-1:0]  bias_r;
  logic [cnn_pkg::IDX_W-1:0]  wgt_cnt;       // Weight row being read
  logic                       wgt_busy;
  logic                       bias_busy;
  logic                       load_active;

  assign kernel_row = kern_mem[row_idx];
  assign bias_val   = bias_r;

  // ============================================================
  // Weight and bias reads run side by side
  // ============================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wgt_req      <= 1'b0;
      bias_req     <= 1'b0;
      wgt_busy     <= 1'b0;
      bias_busy    <= 1'b0;
      wgt_cnt      <= '0;
      load_active  <= 1'b0;
      kernel_ready <= 1'b0;
    end
    else if (job_start)
    begin
      wgt_busy     <= 1'b1;
      bias_busy    <= 1'b1;
      wgt_cnt      <= '0;
      load_active  <= 1'b1;
      kernel_ready <= 1'b0;
    end
    else
    begin
      if (wgt_req && wgt_ack)
      begin
        wgt_req <= 1'b0;
        wgt_cnt <= wgt_cnt + 1'b1;
        if (wgt_cnt == LAST_ROW)
          wgt_busy <= 1'b0;
      end
      else if (wgt_busy && !wgt_req && !wgt_ack)
        wgt_req <= 1'b1;

      if (bias_req && bias_ack)
      begin
        bias_req  <= 1'b0;
        bias_busy <= 1'b0;
      end
      else if (bias_busy && !bias_req && !bias_ack)
        bias_req <= 1'b1;

      if (load_active && !wgt_busy && !bias_busy)
      begin
        load_active  <= 1'b0;
        kernel_ready <= 1'b1;   // Held until the next job
      end
    end
  end

  // Storage and read addresses
  always_ff @(posedge clk)
  begin
    if (job_start)
    begin
      wgt_addr  <= addr_w;
      bias_addr <= addr_bias;
    end
    else if (wgt_req && wgt_ack)
      wgt_addr <= wgt_addr + WGT_STRIDE;
    if (wgt_req && wgt_ack)
      kern_mem[wgt_cnt] <= wgt_data;
    if (bias_req && bias_ack)
      bias_r <= bias_data;
  end

endmodule

// ==== rtl/cnn_mac_activate.sv ====
// Row dot products, window accumulation, bias add and saturating byte activation
module cnn_mac_activate (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          row_valid,
  input  logic [cnn_pkg::ROW_W-1:0]     pic_row,
  input  logic [cnn_pkg::IDX_W-1:0]     row_idx,
  input  logic [cnn_pkg::ROW_W-1:0]     kernel_row,
  input  logic [cnn_pkg::ACC_W-1:0]     bias_val,
  output logic                          result_valid,
  output logic [cnn_pkg::PIX_W-1:0]     result
);

  localparam int PIX_W = cnn_pkg::PIX_W;
  localparam logic [cnn_pkg::IDX_W-1:0] LAST_ROW = cnn_pkg::IDX_W'(cnn_pkg::KERNEL_DIM - 1);

  logic signed [cnn_pkg::ACC_W-1:0] acc;
  logic signed [cnn_pkg::ACC_W-1:0] row_sum;
  logic signed [cnn_pkg::ACC_W-1:0] acc_next;
  logic signed [cnn_pkg::ACC_W-1:0] total;
  logic        [PIX_W-1:0]          act;

  // Unsigned pixel times signed weight, summed over the row
  always_comb
  begin
    logic signed [2*PIX_W:0] prod;
    row_sum = '0;
    for (int j = 0; j < cnn_pkg::KERNEL_DIM; j++)
    begin
      prod    = $signed({1'b0, pic_row[j*PIX_W +: PIX_W]}) *
                $signed(kernel_row[j*PIX_W +: PIX_W]);
      row_sum = row_sum + prod;
    end
  end

  assign acc_next = (row_idx == '0) ? row_sum : acc + row_sum;  // Row 0 starts a new window
  assign total    = acc_next + $signed(bias_val);

  // Clamp to the byte range
  always_comb
  begin
    if (total < 0)
      act = '0;
    else if (total > 255)
      act = '1;
    else
      act = total[PIX_W-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (row_valid)
      acc <= acc_next;
    if (row_valid && row_idx == LAST_ROW)
      result <= act;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      result_valid <= 1'b0;
    else
      result_valid <= row_valid && (row_idx == LAST_ROW);
  end

endmodule

// ==== rtl/cnn_sequencer.sv ====
// Job sequencer, steps the windows, writes each result byte and reports busy and done
module cnn_sequencer #(
  parameter int PIC_ROWS = 8,
  parameter int PIC_COLS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          go,
  input  cnn_pkg::addr_t                addr_x,
  input  cnn_pkg::addr_t                addr_w,
  input  cnn_pkg::addr_t                addr_bias,
  input  cnn_pkg::addr_t                addr_z,
  output logic                          job_start,
  output cnn_pkg::addr_t                job_addr_w,
  output cnn_pkg::addr_t                job_addr_bias,
  output logic                          win_start,
  output cnn_pkg::addr_t                win_base,
  input  logic                          kernel_ready,
  input  logic                          result_valid,
  input  logic [cnn_pkg::PIX_W-1:0]     result,
  output logic                          wr_req,
  output cnn_pkg::addr_t                wr_addr,
  output logic [cnn_pkg::PIX_W-1:0]     wr_data,
  input  logic                          wr_ack,
  output logic                          busy,
  output logic                          done
);

  localparam int OUT_ROWS = PIC_ROWS - cnn_pkg::KERNEL_DIM + 1;
  localparam int OUT_COLS = PIC_COLS - cnn_pkg::KERNEL_DIM + 1;
  localparam int R_W      = $clog2(PIC_ROWS + 1);
  localparam int C_W      = $clog2(PIC_COLS + 1);
  localparam cnn_pkg::addr_t ROW_STRIDE = cnn_pkg::addr_t'(PIC_COLS);

  cnn_pkg::cnn_state_t state;
  logic [R_W-1:0]      win_r;
  logic [C_W-1:0]      win_c;
  cnn_pkg::addr_t      row_base;   // Top-left pixel of the current window row
  logic                go_ok;
  logic                last_col;
  logic                last_win;
  logic                wr_end;

  assign go_ok    = go && !busy;
  assign last_col = (win_c == C_W'(OUT_COLS - 1));
  assign last_win = last_col && (win_r == R_W'(OUT_ROWS - 1));
  assign wr_end   = !wr_req && !wr_ack;  // Handshake over once ack is low again

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= cnn_pkg::IDLE;
      busy      <= 1'b0;
      done      <= 1'b0;
      job_start <= 1'b0;
      win_start <= 1'b0;
      wr_req    <= 1'b0;
      win_r     <= '0;
      win_c     <= '0;
    end
    else
    begin
      job_start <= 1'b0;
      win_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        cnn_pkg::IDLE, cnn_pkg::FINISH:
        begin
          state <= cnn_pkg::IDLE;
          if (go_ok)
          begin
            busy      <= 1'b1;
            job_start <= 1'b1;
            win_start <= 1'b1;   // First window overlaps the kernel load
            win_r     <= '0;
            win_c     <= '0;
            state     <= cnn_pkg::LOAD;
          end
        end

        cnn_pkg::LOAD:
        begin
          // Stale kernel_ready is still up while job_start is
          if (!job_start && kernel_ready)
            state <= cnn_pkg::FETCH;
        end

        cnn_pkg::FETCH:
        begin
          if (result_valid)
          begin
            wr_req <= 1'b1;
            state  <= cnn_pkg::WRITE;
          end
        end

        cnn_pkg::WRITE:
        begin
          if (wr_req && wr_ack)
            wr_req <= 1'b0;
          else if (wr_end)
          begin
            if (last_win)
            begin
              busy  <= 1'b0;
              done  <= 1'b1;
              state <= cnn_pkg::FINISH;
            end
            else
            begin
              win_start <= 1'b1;
              state     <= cnn_pkg::FETCH;
              if (last_col)
              begin
                win_c <= '0;
                win_r <= win_r + 1'b1;
              end
              else
                win_c <= win_c + 1'b1;
            end
          end
        end

        default: state <= cnn_pkg::IDLE;
      endcase
    end
  end

  // ============================================================
  // Job addresses, window bases and write payload
  // ============================================================
  always_ff @(posedge clk)
  begin
    if ((state == cnn_pkg::IDLE || state == cnn_pkg::FINISH) && go_ok)
    begin
      job_addr_w    <= addr_w;
      job_addr_bias <= addr_bias;
      win_base      <= addr_x;
      row_base      <= addr_x;
      wr_addr       <= addr_z;
    end
    else if (state == cnn_pkg::WRITE && wr_end && !last_win)
    begin
      wr_addr <= wr_addr + 1'b1;   // Results are packed row-major
      if (last_col)
      begin
        row_base <= row_base + ROW_STRIDE;
        win_base <= row_base + ROW_STRIDE;
      end
      else
        win_base <= win_base + 1'b1;
    end
    if (state == cnn_pkg::FETCH && result_valid)
      wr_data <= result;
  end

endmodule

// ==== rtl/cnn_top.sv ====
// Convolution engine top level, wires sequencer, fetcher, kernel loader and accumulator
module cnn_top #(
  parameter int PIC_ROWS = 8,
  parameter int PIC_COLS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // Software interface
  input  logic                          go,
  input  cnn_pkg::addr_t                addr_x,
  input  cnn_pkg::addr_t                addr_w,
  input  cnn_pkg::addr_t                addr_bias,
  input  cnn_pkg::addr_t                addr_z,
  output logic                          busy,
  output logic                          done,
  // Memory ports
  output logic                          pic_req,
  output cnn_pkg::addr_t                pic_addr,
  input  logic                          pic_ack,
  input  logic [cnn_pkg::ROW_W-1:0]     pic_data,
  output logic                          wgt_req,
  output cnn_pkg::addr_t                wgt_addr,
  input  logic                          wgt_ack,
  input  logic [cnn_pkg::ROW_W-1:0]     wgt_data,
  output logic                          bias_req,
  output cnn_pkg::addr_t                bias_addr,
  input  logic                          bias_ack,
  input  logic [cnn_pkg::ACC_W-1:0]     bias_data,
  output logic                          wr_req,
  output cnn_pkg::addr_t                wr_addr,
  output logic [cnn_pkg::PIX_W-1:0]     wr_data,
  input  logic                          wr_ack
);

  logic                        job_start;
  cnn_pkg::addr_t              job_addr_w;
  cnn_pkg::addr_t              job_addr_bias;
  logic                        win_start;
  cnn_pkg::addr_t              win_base;
  logic                        kernel_ready;
  logic [cnn_pkg::ROW_W-1:0]   kernel_row;
  logic [cnn_pkg::ACC_W-1:0]   bias_val;
  logic                        row_valid;
  logic [cnn_pkg::ROW_W-1:0]   pic_row;
  logic [cnn_pkg::IDX_W-1:0]   row_idx;
  logic                        result_valid;
  logic [cnn_pkg::PIX_W-1:0]   result;

  cnn_sequencer #(.PIC_ROWS(PIC_ROWS), .PIC_COLS(PIC_COLS)) cnn_sequencer_i (
    .clk, .rst_n, .go, .addr_x, .addr_w, .addr_bias, .addr_z,
    .job_start, .job_addr_w, .job_addr_bias, .win_start, .win_base,
    .kernel_ready, .result_valid, .result,
    .wr_req, .wr_addr, .wr_data, .wr_ack, .busy, .done
  );

  cnn_window_fetch #(.PIC_COLS(PIC_COLS)) cnn_window_fetch_i (
    .clk, .rst_n, .win_start, .win_base, .kernel_ready,
    .pic_req, .pic_addr, .pic_ack, .pic_data,
    .row_valid, .pic_row, .row_idx
  );

  // Kernel rows are picked by the row the fetcher is handing out
  cnn_kernel_load cnn_kernel_load_i (
    .clk, .rst_n, .job_start,
    .addr_w    (job_addr_w),
    .addr_bias (job_addr_bias),
    .wgt_req, .wgt_addr, .bias_req, .bias_addr,
    .wgt_ack, .wgt_data, .bias_ack, .bias_data,
    .row_idx, .kernel_ready, .kernel_row, .bias_val
  );

  cnn_mac_activate cnn_mac_activate_i (
    .clk, .rst_n, .row_valid, .pic_row, .row_idx, .kernel_row, .bias_val,
    .result_valid, .result
  );

endmodule

// ==== verification/cnn_tb.sv ====
// Testbench for the convolution engine with random-delay memory models and result checks
module cnn_tb;

  localparam int PIC_ROWS   = 8;
  localparam int PIC_COLS   = 8;
  localparam int KD         = cnn_pkg::KERNEL_DIM;
  localparam int OUT_COLS   = PIC_COLS - KD + 1;
  localparam int N_OUT      = (PIC_ROWS - KD + 1) * OUT_COLS;
  localparam int MAX_CYCLES = 20000;

  // Test data layout in entries
  localparam int TD_BIAS = 5;                              // After five base addresses
  localparam int TD_PIC  = 6;
  localparam int TD_KERN = TD_PIC + PIC_ROWS * PIC_COLS;
  localparam int TD_EXP  = TD_KERN + KD * KD;
  localparam int TD_LEN  = TD_EXP + N_OUT;

  logic                            clk;
  logic                            rst_n;
  logic                            go;
  cnn_pkg::addr_t                  addr_x;
  cnn_pkg::addr_t                  addr_w;
  cnn_pkg::addr_t                  addr_bias;
  cnn_pkg::addr_t                  addr_z;
  logic                            busy;
  logic                            done;
  logic                            pic_req;
  cnn_pkg::addr_t                  pic_addr;
  logic                            pic_ack;
  logic [cnn_pkg::ROW_W-1:0]       pic_data;
  logic                            wgt_req;
  cnn_pkg::addr_t                  wgt_addr;
  logic                            wgt_ack;
  logic [cnn_pkg::ROW_W-1:0]       wgt_data;
  logic                            bias_req;
  cnn_pkg::addr_t                  bias_addr;
  logic                            bias_ack;
  logic [cnn_pkg::ACC_W-1:0]       bias_data;
  logic                            wr_req;
  cnn_pkg::addr_t                  wr_addr;
  logic [cnn_pkg::PIX_W-1:0]       wr_data;
  logic                            wr_ack;

  logic [31:0]     td [TD_LEN];
  logic [7:0]      mem [0:65535];     // Byte memory behind the read ports
  logic [15:0]     lfsr_state;
  string           test_name;
  cnn_pkg::addr_t  res_base;
  int              pic_count;
  int              wgt_count;
  int              bias_count;
  int              wr_count;

  // Port order 0 picture, 1 weights, 2 bias, 3 write
  logic [3:0]      ack_v;
  logic [3:0]      req_now;
  logic [3:0]      req_prev;
  logic [3:0]      armed;
  cnn_pkg::addr_t  addr_now [4];
  cnn_pkg::addr_t  addr_prev [4];
  int              delay_left [4];

  assign pic_ack  = ack_v[0];
  assign wgt_ack  = ack_v[1];
  assign bias_ack = ack_v[2];
  assign wr_ack   = ack_v[3];

  cnn_top #(.PIC_ROWS(PIC_ROWS), .PIC_COLS(PIC_COLS)) cnn_top_i (.*);

  always #5 clk = ~clk;

  // ============================================================
  // Helpers
  // ============================================================
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] read_word(input cnn_pkg::addr_t a, input int n);
    logic [31:0] w;
    w = '0;
    for (int j = 0; j < n; j++)
      w[8*j +: 8] = mem[cnn_pkg::addr_t'(a + j)];   // Lowest address in the low byte
    return w;
  endfunction

  function automatic string port_name(input int p);
    string names [4];
    names = '{"picture", "weight", "bias", "write"};
    return names[p];
  endfunction

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("Test %s: %s", test_name, what);
    stop_on_error();
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_memory();
    cnn_pkg::addr_t pic_base;
    cnn_pkg::addr_t wgt_base;
    cnn_pkg::addr_t bias_base;
    pic_base  = cnn_pkg::addr_t'(td[0]);
    wgt_base  = cnn_pkg::addr_t'(td[1]);
    bias_base = cnn_pkg::addr_t'(td[2]);
    for (int a = 0; a < 65536; a++)
      mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;             // Background differs per address
    for (int i = 0; i < PIC_ROWS * PIC_COLS; i++)
      mem[cnn_pkg::addr_t'(pic_base + i)] = td[TD_PIC + i][7:0];
    for (int i = 0; i < KD * KD; i++)
      mem[cnn_pkg::addr_t'(wgt_base + i)] = td[TD_KERN + i][7:0];
    for (int k = 0; k < 4; k++)
      mem[cnn_pkg::addr_t'(bias_base + k)] = td[TD_BIAS][8*k +: 8];
  endtask

  // Data for a port in the cycle its ack rises
  task automatic serve_port(input int p);
    int win_idx;
    case (p)
      0:
      begin
        assert (pic_count < N_OUT * KD)
        else report_failure("more picture reads than the windows need");
        win_idx = pic_count / KD;
        check_value("picture address",
                    td[0] + (win_idx / OUT_COLS + pic_count % KD) * PIC_COLS
                    + win_idx % OUT_COLS, pic_addr);
        pic_data = read_word(pic_addr, KD);
        pic_count++;
      end
      1:
      begin
        check_value("weight address", td[1] + wgt_count * KD, wgt_addr);
        wgt_data = read_word(wgt_addr, KD);
        wgt_count++;
      end
      2:
      begin
        check_value("bias address", td[2], bias_addr);
        bias_data = read_word(bias_addr, 4);
        bias_count++;
      end
      default:
      begin
        assert (wr_count < N_OUT)
        else report_failure("more result writes than window positions");
        check_value("write address", res_base + wr_count, wr_addr);
        check_value("write data", td[TD_EXP + wr_count], wr_data);
        wr_count++;
      end
    endcase
  endtask

  // ============================================================
  // Memory models with four-phase ack and random delay
  // ============================================================
  always @(posedge clk)
  begin
    #1;
    req_now     = {wr_req, bias_req, wgt_req, pic_req};
    addr_now[0] = pic_addr;
    addr_now[1] = wgt_addr;
    addr_now[2] = bias_addr;
    addr_now[3] = wr_addr;
    for (int p = 0; p < 4; p++)
    begin
      assert (!(req_now[p] && !req_prev[p] && ack_v[p]))
      else report_failure({port_name(p), " req raised again while its ack was still high"});
      assert (!(req_now[p] && req_prev[p] && addr_now[p] !== addr_prev[p]))
      else report_failure({port_name(p), " address changed while req was high"});
      if (ack_v[p])
      begin
        if (!req_now[p])
          ack_v[p] = 1'b0;                  // Req gone so the handshake ends
      end
      else if (req_now[p])
      begin
        if (!armed[p])
        begin
          delay_left[p] = rand_bits(2);
          armed[p]      = 1'b1;
        end
        if (delay_left[p] == 0)
        begin
          armed[p] = 1'b0;
          ack_v[p] = 1'b1;
          serve_port(p);
        end
        else
          delay_left[p]--;
      end
      req_prev[p]  = req_now[p];
      addr_prev[p] = addr_now[p];
    end
  end

  // ============================================================
  // Job driving and end of job checks
  // ============================================================
  task automatic run_job(input string name, input cnn_pkg::addr_t base);
    int  cycles;
    bit  finished;
    test_name  = name;
    res_base   = base;
    pic_count  = 0;
    wgt_count  = 0;
    bias_count = 0;
    wr_count   = 0;
    addr_x     = cnn_pkg::addr_t'(td[0]);
    addr_w     = cnn_pkg::addr_t'(td[1]);
    addr_bias  = cnn_pkg::addr_t'(td[2]);
    addr_z     = base;
    go         = 1'b1;
    next_cycle();
    go = 1'b0;
    check_value("busy after go", 1, busy);
    cycles   = 0;
    finished = 1'b0;
    while (!finished)
    begin
      next_cycle();
      cycles++;
      assert (cycles < MAX_CYCLES)
      else report_failure("timeout while waiting for done");
      if (cycles == 3)
      begin
        go     = 1'b1;                      // Must be ignored while busy
        addr_z = ~base;
      end
      else if (cycles == 4)
      begin
        go     = 1'b0;
        addr_z = base;
      end
      if (done)
      begin
        check_value("busy at done", 0, busy);
        finished = 1'b1;
      end
      else
        check_value("busy during job", 1, busy);
    end
    check_value("result writes", N_OUT, wr_count);
    check_value("picture handshakes", N_OUT * KD, pic_count);
    check_value("weight handshakes", KD, wgt_count);
    check_value("bias handshakes", 1, bias_count);
    // Done is one pulse and nothing restarts afterwards
    repeat (4)
    begin
      next_cycle();
      check_value("done after job", 0, done);
      check_value("busy after job", 0, busy);
      check_value("req outputs after job", 0, {pic_req, wgt_req, bias_req, wr_req});
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    go         = 1'b0;
    addr_x     = '0;
    addr_w     = '0;
    addr_bias  = '0;
    addr_z     = '0;
    pic_data   = '0;
    wgt_data   = '0;
    bias_data  = '0;
    ack_v      = '0;
    req_prev   = '0;
    armed      = '0;
    lfsr_state = 16'd80;
    res_base   = '0;
    pic_count  = 0;
    wgt_count  = 0;
    bias_count = 0;
    wr_count   = 0;
    test_name  = "reset";
    for (int p = 0; p < 4; p++)
    begin
      addr_prev[p]  = '0;
      delay_left[p] = 0;
    end
    $readmemh("verification/cnn_testdata.txt", td);
    assert (!$isunknown(td[TD_LEN-1]))
    else report_failure("test data file could not be read");
    load_memory();

    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    next_cycle();
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("req outputs", 0, {pic_req, wgt_req, bias_req, wr_req});

    run_job("job_a", cnn_pkg::addr_t'(td[3]));
    run_job("job_b", cnn_pkg::addr_t'(td[4]));   // Same bytes at the other result base

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== verification/cnn_testdata.txt ====
// One hex value per entry: base addresses (picture, weights, bias, result A, result B), bias,
// picture bytes, kernel weights, expected result bytes; rows list column 0 first
0100 0200 0300 0400 0500
fffffffb
// Picture rows, 8 by 8 unsigned bytes
00 01 02 03 04 05 06 07
08 09 f0 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17
18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37
38 39 3a 3b 3c 3d 3e 3f
// Kernel rows, 4 by 4 signed bytes
02 00 00 00
00 00 ff 00
00 00 00 00
00 00 00 01
// Expected result bytes, one line per window row
00 0e 10 12 14
1c 1e ff 22 24
2c 2e 30 32 34
3c 3e 40 42 44
4c 4e 50 52 54

// ==== files.f ====
rtl/cnn_pkg.sv
rtl/cnn_window_fetch.sv
rtl/cnn_kernel_load.sv
rtl/cnn_mac_activate.sv
rtl/cnn_sequencer.sv
rtl/cnn_top.sv
verification/cnn_tb.sv
